// ==== build.f ====
verilog/soc_pkg.sv
verilog/reset_filter.sv
verilog/bus_interconnect.sv
verilog/tcm.sv
verilog/uart.sv
verilog/cycle_timer.sv
verilog/soc_top.sv
testbench/soc_assertions.sv
testbench/tb_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the SoC testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_soc -f build.f -o tb_soc
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_soc > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi

exit 0

// ==== testbench/tb_soc.sv ====
`timescale 1ns/100ps

module tb_soc;

    import soc_pkg::*;

    localparam int CLK_HALF   = 4;
    localparam int MAX_CYCLES = 200000;
    localparam int ACK_LIMIT  = 16;     // Cycles a master waits before giving up on ack.
    localparam int POLL_LIMIT = 200;
    localparam int TCM_WRITES = 200;
    localparam int UART_BYTES = 10;
    localparam int TCM_POOL   = 96;     // Small pool so that words are rewritten often.

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_sel;
    logic [31:0] wb_adr;
    logic [31:0] wb_wdat;
    logic [31:0] wb_rdat;
    logic        wb_ack;
    wire         serial_line;           // Drives i_rx straight from o_tx.

    int          mismatch_count = 0;
    int          other_count = 0;
    int          cycle_count = 0;
    logic [31:0] shadow [int];
    logic [31:0] exp_q [$];
    logic [31:0] act_q [$];
    string       name_q [$];
    time         time_q [$];

    soc_top dut
    (
        .i_clk    (clk),
        .i_reset  (reset),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_sel (wb_sel),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_wdat),
        .o_wb_dat (wb_rdat),
        .o_wb_ack (wb_ack),
        .i_rx     (serial_line),
        .o_tx     (serial_line)
    );

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Byte-lane merge as Wishbone defines it for a partial write.
    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  lanes);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++)
        begin
            if (lanes[i])
            begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    function automatic bit region_unmapped(input logic [31:0] adr);
        return adr[31:28] > 4'd2;           // Only regions 0 to 2 have a slave.
    endfunction

    function automatic logic [7:0] loopback_byte(input logic [7:0] sent);
        return sent;                        // The receiver sees exactly what was sent.
    endfunction

    function automatic logic [31:0] word_address(input logic [3:0] region, input int index);
        return {region, 26'(index), 2'b00};
    endfunction

    // Called one time unit after a rising edge, and returns at the same point.
    task automatic bus_transfer(input  logic        we,
                                input  logic [3:0]  lanes,
                                input  logic [31:0] adr,
                                input  logic [31:0] wdat,
                                output logic [31:0] rdat);
        int waits;
        bit acked;
        waits = 0;
        acked = 0;
        rdat  = '0;
        wb_cyc  = 1'b1;
        wb_stb  = 1'b1;
        wb_we   = we;
        wb_sel  = lanes;
        wb_adr  = adr;
        wb_wdat = wdat;
        while (!acked && waits < ACK_LIMIT)
        begin
            @(posedge clk);
            #1;
            waits++;
            if (wb_ack)
            begin
                acked = 1;
                rdat  = wb_rdat;
            end
        end
        if (!acked)
        begin
            other_count++;
            $display("Error at %0t: no ack for %s of address %h",
                     $time, we ? "write" : "read", adr);
        end
        else
        begin
            @(posedge clk);                 // Request stays up through the ack cycle.
            #1;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [31:0] wdat,
                             input logic [3:0] lanes);
        logic [31:0] unused;
        bus_transfer(1'b1, lanes, adr, wdat, unused);
    endtask

    task automatic bus_read(input logic [31:0] adr, output logic [31:0] rdat);
        bus_transfer(1'b0, 4'hF, adr, 32'd0, rdat);
    endtask

    task automatic expect_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        name_q.push_back(name);
        exp_q.push_back(expected);
        act_q.push_back(actual);
        time_q.push_back($time);
    endtask

    task automatic check_tcm_contents();
        logic [31:0] rdat;
        foreach (shadow[k])
        begin
            bus_read(word_address(REGION_TCM, k), rdat);
            expect_value($sformatf("o_wb_dat (tcm word %0d)", k), shadow[k], rdat);
        end
    endtask

    // Compares queued results half a cycle after they were sampled.
    always @(negedge clk)
    begin
        while (act_q.size() > 0)
        begin
            if (act_q[0] !== exp_q[0])
            begin
                mismatch_count++;
                $display("mismatch at %0t: %s expected %h, got %h",
                         time_q[0], name_q[0], exp_q[0], act_q[0]);
            end
            act_q.delete(0);
            exp_q.delete(0);
            name_q.delete(0);
            time_q.delete(0);
        end
    end

    initial
    begin
        logic [31:0] rdat;
        logic [31:0] wdat;
        logic [31:0] adr;
        logic [31:0] t1;
        logic [31:0] t2;
        logic [31:0] load;
        logic [3:0]  lanes;
        logic [7:0]  tx_byte;
        int          idx;
        int          polls;
        bit          done;

        void'($urandom(1594));
        reset   = 1'b1;
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
        wb_sel  = 4'h0;
        wb_adr  = 32'd0;
        wb_wdat = 32'd0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // The first access only gets its ack once the filtered reset is released.
        bus_read(word_address(REGION_UART, UART_REG_BAUD), rdat);
        expect_value("o_wb_dat (uart baud)", 32'(UART_BAUD_RESET), rdat);
        bus_read(word_address(REGION_UART, UART_REG_STATUS), rdat);
        expect_value("o_wb_dat (uart status)", 32'd0, rdat);

        repeat (TCM_WRITES)
        begin
            idx   = $urandom_range(0, TCM_POOL - 1);
            wdat  = $urandom;
            lanes = 4'($urandom_range(0, 15));
            if (!shadow.exists(idx))
            begin
                lanes       = 4'hF;         // First write to a word defines all of it.
                shadow[idx] = 32'd0;
            end
            bus_write(word_address(REGION_TCM, idx), wdat, lanes);
            shadow[idx] = merge_lanes(shadow[idx], wdat, lanes);
        end
        check_tcm_contents();

        // Same word indices as the TCM pool, so any aliasing would corrupt shadowed words.
        for (int region = 0; region < 16; region++)
        begin
            adr = word_address(4'(region), $urandom_range(0, TCM_POOL - 1));
            if (region_unmapped(adr))
            begin
                bus_read(adr, rdat);
                expect_value("o_wb_dat (unmapped read)", 32'd0, rdat);
                bus_write(adr, $urandom, 4'hF);
            end
        end
        check_tcm_contents();

        bus_write(word_address(REGION_UART, UART_REG_BAUD), 32'd8, 4'hF);
        repeat (UART_BYTES)
        begin
            tx_byte = 8'($urandom);
            bus_write(word_address(REGION_UART, UART_REG_DATA), {24'd0, tx_byte}, 4'h1);
            polls = 0;
            done  = 0;
            while (!done && polls < POLL_LIMIT)
            begin
                bus_read(word_address(REGION_UART, UART_REG_STATUS), rdat);
                polls++;
                done = rdat[1] && !rdat[0];     // Byte received and transmitter idle.
            end
            if (!done)
            begin
                other_count++;
                $display("Error at %0t: UART frame for byte %h not done after %0d polls",
                         $time, tx_byte, POLL_LIMIT);
            end
            else
            begin
                bus_read(word_address(REGION_UART, UART_REG_DATA), rdat);
                expect_value("o_wb_dat (uart rx data)", {24'd0, loopback_byte(tx_byte)}, rdat);
                bus_read(word_address(REGION_UART, UART_REG_STATUS), rdat);
                expect_value("o_wb_dat (uart status after read)", 32'd0, rdat);
            end
        end

        bus_read(word_address(REGION_TIMER, 0), t1);
        bus_read(word_address(REGION_TIMER, 0), t2);
        if (!(t2 > t1))
        begin
            mismatch_count++;
            $display("mismatch at %0t: o_wb_dat (timer) expected above %h, got %h",
                     $time, t1, t2);
        end
        load = $urandom & 32'h7FFF_FFFF;    // Keeps load plus 100 clear of wrap.
        bus_write(word_address(REGION_TIMER, 0), load, 4'hF);
        bus_read(word_address(REGION_TIMER, 0), t1);
        if (t1 < load || t1 >= load + 32'd100)
        begin
            mismatch_count++;
            $display("mismatch at %0t: o_wb_dat (timer after load) expected %h to %h, got %h",
                     $time, load, load + 32'd99, t1);
        end

        repeat (2) @(posedge clk);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count + other_count == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/soc_assertions.sv ====
`timescale 1ns/100ps

module soc_assertions
(
    input logic i_clk,
    input logic i_reset,
    input logic i_int_reset,
    input logic i_cyc,
    input logic i_stb,
    input logic i_ack,
    input logic i_tcm_ack,
    input logic i_uart_ack,
    input logic i_timer_ack,
    input logic i_tx
);

    // An acknowledge must always answer a live request.
    a_ack_needs_request: assert property (@(posedge i_clk) disable iff (i_reset)
        i_ack |-> (i_cyc && i_stb))
        else $error("ack seen without cyc and stb");

    a_ack_single_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
        i_ack |=> !i_ack)
        else $error("ack held for more than one cycle");   // Slaves pulse ack once.

    // Only the slave of the decoded region may answer.
    a_slave_ack_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
        $onehot0({i_tcm_ack, i_uart_ack, i_timer_ack}))
        else $error("more than one slave ack active");

    // The transmitter leaves reset with the line idle.
    a_tx_idle_after_reset: assert property (@(posedge i_clk)
        $fell(i_int_reset) |-> i_tx)
        else $error("tx line not idle when internal reset released");

endmodule

bind soc_top soc_assertions u_soc_assertions
(
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_int_reset (w_reset),
    .i_cyc       (i_wb_cyc),
    .i_stb       (i_wb_stb),
    .i_ack       (o_wb_ack),
    .i_tcm_ack   (tcm_ack),
    .i_uart_ack  (uart_ack),
    .i_timer_ack (timer_ack),
    .i_tx        (o_tx)
);

// ==== verilog/soc_top.sv ====
`timescale 1ns/100ps

module soc_top
(
    input  logic                             i_clk,
    input  logic                             i_reset,
    input  logic                             i_wb_cyc,
    input  logic                             i_wb_stb,
    input  logic                             i_wb_we,
    input  logic [soc_pkg::DATA_WIDTH/8-1:0] i_wb_sel,
    input  logic [soc_pkg::DATA_WIDTH-1:0]   i_wb_adr,
    input  logic [soc_pkg::DATA_WIDTH-1:0]   i_wb_dat,
    output logic [soc_pkg::DATA_WIDTH-1:0]   o_wb_dat,
    output logic                             o_wb_ack,
    input  logic                             i_rx,
    output logic                             o_tx
);

    import soc_pkg::*;

    logic                  w_reset;
    logic                  tcm_sel;
    logic                  uart_sel;
    logic                  timer_sel;
    logic [DATA_WIDTH-1:0] tcm_dat;
    logic [DATA_WIDTH-1:0] uart_dat;
    logic [DATA_WIDTH-1:0] timer_dat;
    logic                  tcm_ack;
    logic                  uart_ack;
    logic                  timer_ack;

    // Everything below runs on the filtered reset.
    reset_filter u_reset_filter
    (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .o_reset     (w_reset)
    );

    bus_interconnect u_interconnect
    (
        .i_clk       (i_clk),
        .i_reset     (w_reset),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_adr    (i_wb_adr),
        .o_tcm_sel   (tcm_sel),
        .o_uart_sel  (uart_sel),
        .o_timer_sel (timer_sel),
        .i_tcm_dat   (tcm_dat),
        .i_tcm_ack   (tcm_ack),
        .i_uart_dat  (uart_dat),
        .i_uart_ack  (uart_ack),
        .i_timer_dat (timer_dat),
        .i_timer_ack (timer_ack),
        .o_wb_dat    (o_wb_dat),
        .o_wb_ack    (o_wb_ack)
    );

    tcm u_tcm
    (
        .i_clk       (i_clk),
        .i_sel       (tcm_sel),
        .i_wb_we     (i_wb_we),
        .i_wb_sel    (i_wb_sel),
        .i_wb_adr    (i_wb_adr),
        .i_wb_dat    (i_wb_dat),
        .o_dat       (tcm_dat),
        .o_ack       (tcm_ack)
    );

    uart u_uart
    (
        .i_clk       (i_clk),
        .i_reset     (w_reset),
        .i_sel       (uart_sel),
        .i_wb_we     (i_wb_we),
        .i_wb_adr    (i_wb_adr),
        .i_wb_dat    (i_wb_dat),
        .o_dat       (uart_dat),
        .o_ack       (uart_ack),
        .i_rx        (i_rx),
        .o_tx        (o_tx)
    );

    cycle_timer u_timer
    (
        .i_clk       (i_clk),
        .i_reset     (w_reset),
        .i_sel       (timer_sel),
        .i_wb_we     (i_wb_we),
        .i_wb_dat    (i_wb_dat),
        .o_dat       (timer_dat),
        .o_ack       (timer_ack)
    );

endmodule

// ==== verilog/cycle_timer.sv ====
`timescale 1ns/100ps

module cycle_timer
(
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_sel,
    input  logic                           i_wb_we,
    input  logic [soc_pkg::DATA_WIDTH-1:0] i_wb_dat,
    output logic [soc_pkg::DATA_WIDTH-1:0] o_dat,
    output logic                           o_ack
);

    import soc_pkg::*;

    logic                  w_access;
    logic                  r_ack;
    logic [DATA_WIDTH-1:0] r_count;
    logic [DATA_WIDTH-1:0] r_dat;

    assign w_access = i_sel && !r_ack;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            r_ack   <= 1'b0;
            r_count <= '0;
        end
        else
        begin
            r_ack <= w_access;
            // A load replaces the increment for that cycle.
            r_count <= (w_access && i_wb_we) ? i_wb_dat : r_count + 1'b1;
        end
    end

    // Snapshot taken as the transfer is accepted.
    always_ff @(posedge i_clk)
    begin
        if (w_access)
        begin
            r_dat <= r_count;
        end
    end

    assign o_ack = r_ack;
    assign o_dat = r_dat;

endmodule

// ==== verilog/uart.sv ====
`timescale 1ns/100ps

module uart
(
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_sel,
    input  logic                           i_wb_we,
    input  logic [soc_pkg::DATA_WIDTH-1:0] i_wb_adr,
    input  logic [soc_pkg::DATA_WIDTH-1:0] i_wb_dat,
    output logic [soc_pkg::DATA_WIDTH-1:0] o_dat,
    output logic                           o_ack,
    input  logic                           i_rx,
    output logic                           o_tx
);

    import soc_pkg::*;

    bus_addr_t                  w_adr;
    logic [1:0]                 w_reg;
    logic                       w_access;
    logic                       r_ack;
    logic [DATA_WIDTH-1:0]      r_dat;
    logic [UART_BAUD_WIDTH-1:0] r_baud;
    logic                       r_tx_busy;
    logic [9:0]                 r_tx_shift;
    logic [3:0]                 r_tx_bit;
    logic [UART_BAUD_WIDTH-1:0] r_tx_cnt;
    logic [1:0]                 r_rx_sync;
    logic                       r_rx_busy;
    logic [3:0]                 r_rx_bit;
    logic [UART_BAUD_WIDTH-1:0] r_rx_cnt;
    logic [7:0]                 r_rx_shift;
    logic [7:0]                 r_rx_data;
    logic                       r_rx_valid;

    assign w_adr    = i_wb_adr;
    assign w_reg    = w_adr.wrd.index[1:0];
    assign w_access = i_sel && !r_ack;

    // Bus side with registered read data, baud register and ack.
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            r_ack  <= 1'b0;
            r_baud <= UART_BAUD_RESET;
        end
        else
        begin
            r_ack <= w_access;
            if (w_access && i_wb_we && w_reg == UART_REG_BAUD)
            begin
                r_baud <= i_wb_dat[UART_BAUD_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (w_access)
        begin
            case (w_reg)
                UART_REG_DATA:   r_dat <= DATA_WIDTH'(r_rx_data);
                UART_REG_STATUS: r_dat <= DATA_WIDTH'({r_rx_valid, r_tx_busy});
                UART_REG_BAUD:   r_dat <= DATA_WIDTH'(r_baud);
                default:         r_dat <= '0;
            endcase
        end
    end

    // Transmitter. The shifter holds start, data and stop bits, LSB out first.
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            r_tx_busy  <= 1'b0;
            r_tx_shift <= '1;                   // Line idles high.
            r_tx_bit   <= '0;
            r_tx_cnt   <= '0;
        end
        else if (!r_tx_busy)
        begin
            if (w_access && i_wb_we && w_reg == UART_REG_DATA)
            begin
                r_tx_shift <= {1'b1, i_wb_dat[7:0], 1'b0};
                r_tx_busy  <= 1'b1;
                r_tx_bit   <= '0;
                r_tx_cnt   <= '0;
            end
        end
        else if (r_tx_cnt == r_baud - 1'b1)
        begin
            r_tx_cnt   <= '0;
            r_tx_shift <= {1'b1, r_tx_shift[9:1]};
            r_tx_bit   <= r_tx_bit + 1'b1;
            if (r_tx_bit == 4'd9)
            begin
                r_tx_busy <= 1'b0;              // Stop bit has been on the line long enough.
            end
        end
        else
        begin
            r_tx_cnt <= r_tx_cnt + 1'b1;
        end
    end

    assign o_tx = r_tx_shift[0];

    // Receiver. The first sample lands half a bit after the start edge.
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            r_rx_sync  <= 2'b11;
            r_rx_busy  <= 1'b0;
            r_rx_valid <= 1'b0;
        end
        else
        begin
            r_rx_sync <= {r_rx_sync[0], i_rx};
            if (w_access && !i_wb_we && w_reg == UART_REG_DATA)
            begin
                r_rx_valid <= 1'b0;             // Reading DATA consumes the byte.
            end
            if (!r_rx_busy)
            begin
                if (!r_rx_sync[1])
                begin
                    r_rx_busy <= 1'b1;
                    r_rx_bit  <= '0;
                    r_rx_cnt  <= r_baud >> 1;
                end
            end
            else if (r_rx_cnt != '0)
            begin
                r_rx_cnt <= r_rx_cnt - 1'b1;
            end
            else
            begin
                r_rx_cnt <= r_baud - 1'b1;
                r_rx_bit <= r_rx_bit + 1'b1;
                if (r_rx_bit == 4'd0 && r_rx_sync[1])
                begin
                    r_rx_busy <= 1'b0;          // Start bit did not hold, so it was noise.
                end
                else if (r_rx_bit == 4'd9)
                begin
                    r_rx_busy <= 1'b0;
                    if (r_rx_sync[1])
                    begin
                        r_rx_data  <= r_rx_shift;
                        r_rx_valid <= 1'b1;
                    end
                end
                else if (r_rx_bit != 4'd0)
                begin
                    r_rx_shift <= {r_rx_sync[1], r_rx_shift[7:1]};
                end
            end
        end
    end

    assign o_ack = r_ack;
    assign o_dat = r_dat;

endmodule

// ==== verilog/tcm.sv ====
`timescale 1ns/100ps

module tcm
(
    input  logic                             i_clk,
    input  logic                             i_sel,
    input  logic                             i_wb_we,
    input  logic [soc_pkg::DATA_WIDTH/8-1:0] i_wb_sel,
    input  logic [soc_pkg::DATA_WIDTH-1:0]   i_wb_adr,
    input  logic [soc_pkg::DATA_WIDTH-1:0]   i_wb_dat,
    output logic [soc_pkg::DATA_WIDTH-1:0]   o_dat,
    output logic                             o_ack
);

    import soc_pkg::*;

    logic [DATA_WIDTH-1:0]     r_mem [0:(1 << TCM_ADDR_WIDTH)-1];
    bus_addr_t                 w_adr;
    logic [TCM_ADDR_WIDTH-1:0] w_index;
    logic                      w_access;
    logic                      r_ack;
    logic [DATA_WIDTH-1:0]     r_dat;

    assign w_adr    = i_wb_adr;
    assign w_index  = w_adr.wrd.index[TCM_ADDR_WIDTH-1:0];    // Upper index bits alias.
    assign w_access = i_sel && !r_ack;                        // First cycle of a transfer.

    // Ack rises in the cycle after the select and lasts one cycle.
    always_ff @(posedge i_clk)
    begin
        r_ack <= w_access;
    end

    always_ff @(posedge i_clk)
    begin
        if (w_access)
        begin
            r_dat <= r_mem[w_index];
        end
    end

    // Only the enabled byte lanes are written.
    always_ff @(posedge i_clk)
    begin
        if (w_access && i_wb_we)
        begin
            for (int lane = 0; lane < DATA_WIDTH/8; lane++)
            begin
                if (i_wb_sel[lane])
                begin
                    r_mem[w_index][8*lane +: 8] <= i_wb_dat[8*lane +: 8];
                end
            end
        end
    end

    assign o_ack = r_ack;
    assign o_dat = r_dat;

endmodule

// ==== verilog/bus_interconnect.sv ====
`timescale 1ns/100ps

module bus_interconnect
(
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_wb_cyc,
    input  logic                           i_wb_stb,
    input  logic [soc_pkg::DATA_WIDTH-1:0] i_wb_adr,
    output logic                           o_tcm_sel,
    output logic                           o_uart_sel,
    output logic                           o_timer_sel,
    input  logic [soc_pkg::DATA_WIDTH-1:0] i_tcm_dat,
    input  logic                           i_tcm_ack,
    input  logic [soc_pkg::DATA_WIDTH-1:0] i_uart_dat,
    input  logic                           i_uart_ack,
    input  logic [soc_pkg::DATA_WIDTH-1:0] i_timer_dat,
    input  logic                           i_timer_ack,
    output logic [soc_pkg::DATA_WIDTH-1:0] o_wb_dat,
    output logic                           o_wb_ack
);

    import soc_pkg::*;

    bus_addr_t w_adr;
    logic      w_req;
    logic      w_unmapped_sel;
    logic      r_unmapped_ack;

    assign w_adr = i_wb_adr;
    assign w_req = i_wb_cyc && i_wb_stb;

    // One-hot selects, since the region field has a single value at a time.
    assign o_tcm_sel   = w_req && (w_adr.rgn.region == REGION_TCM);
    assign o_uart_sel  = w_req && (w_adr.rgn.region == REGION_UART);
    assign o_timer_sel = w_req && (w_adr.rgn.region == REGION_TIMER);

    assign w_unmapped_sel = w_req && !o_tcm_sel && !o_uart_sel && !o_timer_sel;

    // Regions 3 to 15 get a default slave so the master never waits forever.
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            r_unmapped_ack <= 1'b0;
        end
        else
        begin
            r_unmapped_ack <= w_unmapped_sel && !r_unmapped_ack;
        end
    end

    // The master holds the address until ack, so the region still steers the return path.
    always_comb
    begin
        case (w_adr.rgn.region)
            REGION_TCM:
            begin
                o_wb_dat = i_tcm_dat;
                o_wb_ack = i_tcm_ack;
            end
            REGION_UART:
            begin
                o_wb_dat = i_uart_dat;
                o_wb_ack = i_uart_ack;
            end
            REGION_TIMER:
            begin
                o_wb_dat = i_timer_dat;
                o_wb_ack = i_timer_ack;
            end
            default:
            begin
                o_wb_dat = '0;                  // Unmapped reads return zero.
                o_wb_ack = r_unmapped_ack;
            end
        endcase
    end

endmodule

// ==== verilog/reset_filter.sv ====
`timescale 1ns/100ps

module reset_filter
(
    input  logic i_clk,
    input  logic i_reset,
    output logic o_reset
);

    import soc_pkg::*;

    // Counts clean cycles since the last time i_reset was seen high.
    logic [$clog2(RESET_FILTER_CYCLES+1)-1:0] r_count;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            r_count <= '0;                      // Any pulse restarts the wait.
        end
        else if (o_reset)
        begin
            r_count <= r_count + 1'b1;          // Stops once the count is reached.
        end
    end

    // Asserted at once with the external reset, released only after
    // RESET_FILTER_CYCLES quiet cycles.
    assign o_reset = i_reset || (int'(r_count) != RESET_FILTER_CYCLES);

endmodule

// ==== verilog/soc_pkg.sv ====
package soc_pkg;

    // Bus word and memory map.
    localparam int DATA_WIDTH      = 32;
    localparam int REGION_BITS     = 4;
    localparam int WORD_INDEX_BITS = DATA_WIDTH - REGION_BITS - 2;

    localparam logic [REGION_BITS-1:0] REGION_TCM   = 4'd0;
    localparam logic [REGION_BITS-1:0] REGION_UART  = 4'd1;
    localparam logic [REGION_BITS-1:0] REGION_TIMER = 4'd2;

    localparam int TCM_ADDR_WIDTH      = 10;    // 1024 words.
    localparam int RESET_FILTER_CYCLES = 4;

    // UART register map, as word offsets inside region 1.
    localparam logic [1:0] UART_REG_DATA   = 2'd0;
    localparam logic [1:0] UART_REG_STATUS = 2'd1;
    localparam logic [1:0] UART_REG_BAUD   = 2'd2;

    localparam int                   UART_BAUD_WIDTH = 16;
    localparam logic [UART_BAUD_WIDTH-1:0] UART_BAUD_RESET = 16'd16;  // Clocks per bit.

    // The interconnect looks at the region view, the slaves at the word view.
    typedef union packed
    {
        struct packed
        {
            logic [REGION_BITS-1:0]            region;
            logic [DATA_WIDTH-REGION_BITS-1:0] offset;
        } rgn;
        struct packed
        {
            logic [REGION_BITS-1:0]     region;
            logic [WORD_INDEX_BITS-1:0] index;
            logic [1:0]                 byte_off;
        } wrd;
    } bus_addr_t;

endpackage
